//--- gsm_switch.f
source/gsm_pkg.sv
source/gsm_ingress_arb.sv
source/gsm_hdr_parse.sv
source/gsm_cell_buffer.sv
source/gsm_egress_sched.sv
source/gsm_switch.sv
verif/gsm_switch_tb.sv

//--- Bender.yml
package:
  name: gsm_switch

sources:
  - source/gsm_pkg.sv
  - source/gsm_ingress_arb.sv
  - source/gsm_hdr_parse.sv
  - source/gsm_cell_buffer.sv
  - source/gsm_egress_sched.sv
  - source/gsm_switch.sv
  - target: test
    files:
      - verif/gsm_switch_tb.sv

//--- verif/gsm_switch_tb.sv
// ----------------------------------------------------------
// testbench for the 4x4 shared-memory switch, BUF_AW 5
// inputs change 1 unit after the rising edge, outputs are
// sampled on the falling edge
// expected cells are kept per source and egress port
// ----------------------------------------------------------
module gsm_switch_tb;
	import gsm_pkg::*;

	localparam int WAIT_LIMIT = 5000;

	logic clk_80M;
	logic i_rst;
	logic [N_PORTS-1:0] in_valid;
	in_cell_t in_cell [N_PORTS];
	logic [N_PORTS-1:0] o_in_ready;
	logic [N_PORTS-1:0] o_out_valid;
	out_cell_t o_out_cell [N_PORTS];
	logic [N_PORTS-1:0] out_ready;

	integer seed = 97;
	logic rand_ready;
	int cur_src [N_PORTS];
	logic [7:0] seq_no [N_PORTS];
	logic [N_PORTS-1:0] stalled;
	out_cell_t held_cell [N_PORTS];
	// index is source * N_PORTS + egress port
	out_cell_t exp_q [N_PORTS*N_PORTS][$];

	gsm_switch #(.BUF_AW(5)) u_dut (
		.clk_80M(clk_80M),
		.i_rst(i_rst),
		.i_in_valid(in_valid),
		.i_in_cell(in_cell),
		.o_in_ready(o_in_ready),
		.o_out_valid(o_out_valid),
		.o_out_cell(o_out_cell),
		.i_out_ready(out_ready)
	);

	always #4 clk_80M = ~clk_80M;

	// egress back-pressure, all ready unless random mode is on
	always @(posedge clk_80M) begin
		if (rand_ready) begin
			out_ready <= #1 port_mask_t'($random(seed));
		end else begin
			out_ready <= #1 '1;
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	function automatic int pending_cells();
		int n;
		n = 0;
		for (int k = 0; k < N_PORTS * N_PORTS; k++) begin
			n += exp_q[k].size();
		end
		return n;
	endfunction

	// ------------------------------------------------------------
	// egress monitor
	// ------------------------------------------------------------
	task automatic check_egress(input int p);
		out_cell_t got;
		out_cell_t exp;
		int s;
		got = o_out_cell[p];
		if (got.first) begin
			assert (cur_src[p] < 0) else
				stop_on_error($sformatf("ERR o_out_cell[%0d].first exp %h act %h",
					p, 1'b0, 1'b1));
			cur_src[p] = int'(got.data[HDR_SRC_LSB +: 8]);
		end
		assert (cur_src[p] >= 0 && cur_src[p] < N_PORTS) else
			stop_on_error($sformatf("egress port %0d sent a cell outside any packet", p));
		s = cur_src[p];
		assert (exp_q[s * N_PORTS + p].size() > 0) else
			stop_on_error($sformatf("egress port %0d sent a cell nobody expected from source %0d",
				p, s));
		exp = exp_q[s * N_PORTS + p].pop_front();
		assert (got == exp) else
			stop_on_error($sformatf("ERR o_out_cell[%0d] exp %h act %h", p, exp, got));
		if (got.last) begin
			cur_src[p] = -1;
		end
	endtask

	// a stalled egress cell must stay unchanged until it is taken
	task automatic check_hold(input int p);
		if (stalled[p]) begin
			assert (o_out_valid[p]) else
				stop_on_error($sformatf("egress port %0d dropped valid while stalled", p));
			assert (o_out_cell[p] == held_cell[p]) else
				stop_on_error($sformatf("ERR o_out_cell[%0d] exp %h act %h", p,
					held_cell[p], o_out_cell[p]));
		end
		stalled[p] = o_out_valid[p] && !out_ready[p];
		held_cell[p] = o_out_cell[p];
	endtask

	always @(negedge clk_80M) begin
		if (!i_rst) begin
			for (int p = 0; p < N_PORTS; p++) begin
				check_hold(p);
				if (o_out_valid[p] && out_ready[p]) begin
					check_egress(p);
				end
			end
		end
	end

	// ------------------------------------------------------------
	// ingress drivers
	// ------------------------------------------------------------
	task automatic drive_cell(input int p, input in_cell_t c);
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		in_cell[p] = c;
		in_valid[p] = 1'b1;
		while (!taken) begin
			@(negedge clk_80M);
			if (o_in_ready[p]) begin
				taken = 1'b1;
			end else begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					stop_on_error($sformatf("ingress port %0d never accepted its cell", p));
				end
			end
		end
		@(posedge clk_80M);
		#1;
		in_valid[p] = 1'b0;
	endtask

	task automatic send_packet(input int p, input port_mask_t mask, input cell_cnt_t cnt);
		in_cell_t c;
		out_cell_t e;
		for (int k = 0; k <= int'(cnt); k++) begin
			c.data = {$random(seed), $random(seed)};
			c.hdr = (k == 0);
			if (k == 0) begin
				c.data[HDR_SEQ_LSB +: 8] = seq_no[p];
				c.data[HDR_SRC_LSB +: 8] = 8'(p);
				c.data[HDR_CNT_LSB +: 4] = cnt;
				c.data[HDR_MASK_LSB +: N_PORTS] = mask;
			end
			e.data = c.data;
			e.first = (k == 0);
			e.last = (k == int'(cnt));
			for (int q = 0; q < N_PORTS; q++) begin
				if (mask[q]) begin
					exp_q[p * N_PORTS + q].push_back(e);
				end
			end
			drive_cell(p, c);
		end
		seq_no[p] = seq_no[p] + 8'd1;
	endtask

	task automatic run_port(input int p, input int npkt);
		port_mask_t m;
		for (int n = 0; n < npkt; n++) begin
			m = port_mask_t'($random(seed));
			if (m == '0) begin
				m = port_mask_t'(1 << p);
			end
			send_packet(p, m, cell_cnt_t'($random(seed)));
		end
	endtask

	// polled just after the rising edge, so the monitor has already run
	task automatic wait_drain(input string what);
		int waited;
		waited = 0;
		while (pending_cells() != 0 || o_out_valid != '0) begin
			@(posedge clk_80M);
			#1;
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_error($sformatf("egress never drained after the %s test", what));
			end
		end
	endtask

	task automatic check_idle_outputs();
		assert (o_out_valid == '0) else
			stop_on_error($sformatf("ERR o_out_valid exp %h act %h", 4'h0, o_out_valid));
		assert (o_in_ready == '0) else
			stop_on_error($sformatf("ERR o_in_ready exp %h act %h", 4'h0, o_in_ready));
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		clk_80M = 1'b0;
		i_rst = 1'b1;
		in_valid = '0;
		out_ready = '1;
		rand_ready = 1'b0;
		stalled = '0;
		for (int p = 0; p < N_PORTS; p++) begin
			in_cell[p] = '0;
			cur_src[p] = -1;
			seq_no[p] = '0;
			held_cell[p] = '0;
		end

		// four reset edges, outputs checked from the first one on
		@(posedge clk_80M);
		for (int k = 0; k < 3; k++) begin
			@(negedge clk_80M);
			check_idle_outputs();
			@(posedge clk_80M);
		end
		#1;
		i_rst = 1'b0;
		@(negedge clk_80M);
		check_idle_outputs();
		@(posedge clk_80M);
		#1;

		send_packet(0, 4'b0100, 4'd3);
		wait_drain("unicast");
		send_packet(1, 4'b1011, 4'd5);
		wait_drain("multicast");

		fork
			run_port(0, 6);
			run_port(1, 6);
			run_port(2, 6);
			run_port(3, 6);
		join
		wait_drain("all ports");

		rand_ready = 1'b1;
		fork
			run_port(0, 10);
			run_port(1, 10);
			run_port(2, 10);
			run_port(3, 10);
		join
		wait_drain("random ready");
		rand_ready = 1'b0;

		// dropped packet, then more than the whole buffer of cells
		send_packet(2, 4'b0000, 4'd4);
		for (int n = 0; n < 3; n++) begin
			send_packet(3, 4'b0110, 4'd15);
		end
		wait_drain("buffer reuse");
		// idle tail so a stray late cell still meets the monitor
		repeat (16) @(posedge clk_80M);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- source/gsm_switch.sv
// ----------------------------------------------------------
// 4x4 shared-memory packet switch, single clock
// pipeline: arbiter, header parse, cell buffer, scheduler
// first-cell latency is 4 cycles or more
// ----------------------------------------------------------
module gsm_switch #(
	parameter int BUF_AW = 5
) (
	input  logic clk_80M,
	input  logic i_rst,
	input  logic [gsm_pkg::N_PORTS-1:0] i_in_valid,
	input  gsm_pkg::in_cell_t i_in_cell [gsm_pkg::N_PORTS],
	output logic [gsm_pkg::N_PORTS-1:0] o_in_ready,
	output logic [gsm_pkg::N_PORTS-1:0] o_out_valid,
	output gsm_pkg::out_cell_t o_out_cell [gsm_pkg::N_PORTS],
	input  logic [gsm_pkg::N_PORTS-1:0] i_out_ready
);
	import gsm_pkg::*;

	// arbiter to parser
	logic arb_valid;
	logic arb_ready;
	in_cell_t arb_cell;
	port_idx_t arb_src;

	// parser to buffer
	logic par_valid;
	logic par_ready;
	tag_cell_t par_cell;

	// buffer and scheduler
	port_mask_t q_nonempty;
	logic [BUF_AW-1:0] q_head [N_PORTS];
	logic rd_req;
	port_idx_t rd_port;
	logic [BUF_AW-1:0] rd_addr;
	out_cell_t rd_data;

	gsm_ingress_arb u_arb (
		.clk_80M(clk_80M),
		.i_rst(i_rst),
		.i_in_valid(i_in_valid),
		.i_in_cell(i_in_cell),
		.o_in_ready(o_in_ready),
		.o_arb_valid(arb_valid),
		.o_arb_cell(arb_cell),
		.o_arb_src(arb_src),
		.i_arb_ready(arb_ready)
	);

	gsm_hdr_parse u_parse (
		.clk_80M(clk_80M),
		.i_rst(i_rst),
		.i_arb_valid(arb_valid),
		.i_arb_cell(arb_cell),
		.i_arb_src(arb_src),
		.o_arb_ready(arb_ready),
		.o_par_valid(par_valid),
		.o_par_cell(par_cell),
		.i_par_ready(par_ready)
	);

	gsm_cell_buffer #(.BUF_AW(BUF_AW)) u_buf (
		.clk_80M(clk_80M),
		.i_rst(i_rst),
		.i_par_valid(par_valid),
		.i_par_cell(par_cell),
		.o_par_ready(par_ready),
		.o_q_nonempty(q_nonempty),
		.o_q_head(q_head),
		.i_rd_req(rd_req),
		.i_rd_port(rd_port),
		.i_rd_addr(rd_addr),
		.o_rd_data(rd_data)
	);

	gsm_egress_sched #(.BUF_AW(BUF_AW)) u_sched (
		.clk_80M(clk_80M),
		.i_rst(i_rst),
		.i_q_nonempty(q_nonempty),
		.i_q_head(q_head),
		.o_rd_req(rd_req),
		.o_rd_port(rd_port),
		.o_rd_addr(rd_addr),
		.i_rd_data(rd_data),
		.o_out_valid(o_out_valid),
		.o_out_cell(o_out_cell),
		.i_out_ready(i_out_ready)
	);

endmodule

//--- source/gsm_egress_sched.sv
// ----------------------------------------------------------
// egress scheduler, one buffer read per cycle
// a port is read only if its output register is free
// when the data returns, in-flight reads included
// ----------------------------------------------------------
module gsm_egress_sched #(
	parameter int BUF_AW = 5
) (
	input  logic clk_80M,
	input  logic i_rst,
	input  gsm_pkg::port_mask_t i_q_nonempty,
	input  logic [BUF_AW-1:0] i_q_head [gsm_pkg::N_PORTS],
	output logic o_rd_req,
	output gsm_pkg::port_idx_t o_rd_port,
	output logic [BUF_AW-1:0] o_rd_addr,
	input  gsm_pkg::out_cell_t i_rd_data,
	output logic [gsm_pkg::N_PORTS-1:0] o_out_valid,
	output gsm_pkg::out_cell_t o_out_cell [gsm_pkg::N_PORTS],
	input  logic [gsm_pkg::N_PORTS-1:0] i_out_ready
);
	import gsm_pkg::*;

	port_idx_t rr_ptr;
	port_idx_t pend_port;
	logic pend_valid;
	port_mask_t in_flight;
	port_mask_t elig;

	always_comb begin
		in_flight = '0;
		if (pend_valid) begin
			in_flight[pend_port] = 1'b1;
		end
	end

	assign elig = i_q_nonempty & ~in_flight & (~o_out_valid | i_out_ready);

	// round-robin pick over eligible ports
	always_comb begin
		port_idx_t idx;
		o_rd_req = 1'b0;
		o_rd_port = rr_ptr;
		for (int k = 0; k < N_PORTS; k++) begin
			idx = rr_ptr + port_idx_t'(k);
			if (!o_rd_req && elig[idx]) begin
				o_rd_req = 1'b1;
				o_rd_port = idx;
			end
		end
	end

	assign o_rd_addr = i_q_head[o_rd_port];

	always_ff @(posedge clk_80M) begin
		if (i_rst) begin
			rr_ptr <= '0;
			pend_valid <= 1'b0;
			o_out_valid <= '0;
		end else begin
			pend_valid <= o_rd_req;
			if (o_rd_req) begin
				rr_ptr <= o_rd_port + 1'b1;
			end
			for (int p = 0; p < N_PORTS; p++) begin
				if (in_flight[p]) begin
					o_out_valid[p] <= 1'b1;
				end else if (i_out_ready[p]) begin
					o_out_valid[p] <= 1'b0;
				end
			end
		end
	end

	// read data lands in the register of the port it was issued for
	always_ff @(posedge clk_80M) begin
		pend_port <= o_rd_port;
		for (int p = 0; p < N_PORTS; p++) begin
			if (in_flight[p]) begin
				o_out_cell[p] <= i_rd_data;
			end
		end
	end

	for (genvar p = 0; p < N_PORTS; p++) begin : g_hold
		a_out_hold: assert property (@(posedge clk_80M) disable iff (i_rst)
			(o_out_valid[p] && !i_out_ready[p]) |=>
			(o_out_valid[p] && $stable(o_out_cell[p])));
	end

endmodule

//--- source/gsm_cell_buffer.sv
// ----------------------------------------------------------
// shared cell memory, 2**BUF_AW cells for all ports
// each egress queue holds at most half of the cells
// multicast cells are stored once with a reference count
// read data comes one cycle after the read request
// ----------------------------------------------------------
module gsm_cell_buffer #(
	parameter int BUF_AW = 5
) (
	input  logic clk_80M,
	input  logic i_rst,
	input  logic i_par_valid,
	input  gsm_pkg::tag_cell_t i_par_cell,
	output logic o_par_ready,
	output gsm_pkg::port_mask_t o_q_nonempty,
	output logic [BUF_AW-1:0] o_q_head [gsm_pkg::N_PORTS],
	input  logic i_rd_req,
	input  gsm_pkg::port_idx_t i_rd_port,
	input  logic [BUF_AW-1:0] i_rd_addr,
	output gsm_pkg::out_cell_t o_rd_data
);
	import gsm_pkg::*;

	localparam int DEPTH = 1 << BUF_AW;
	localparam int QAW = BUF_AW - 1;
	localparam int QDEPTH = 1 << QAW;
	localparam int RCW = $clog2(N_PORTS + 1);

	typedef logic [BUF_AW-1:0] addr_t;
	typedef logic [RCW-1:0] ref_t;

	out_cell_t mem [DEPTH];
	ref_t ref_cnt [DEPTH];
	addr_t free_mem [DEPTH];
	addr_t free_rd;
	addr_t free_wr;
	logic [BUF_AW:0] free_cnt;
	addr_t q_mem [N_PORTS][QDEPTH];
	logic [QAW-1:0] q_rd [N_PORTS];
	logic [QAW-1:0] q_wr [N_PORTS];
	logic [QAW:0] q_cnt [N_PORTS];
	port_mask_t q_full;
	port_mask_t push;
	port_mask_t pop;
	logic store;
	logic free_push;
	addr_t wr_addr;

	function automatic ref_t mask_refs(port_mask_t m);
		ref_t n;
		n = '0;
		for (int k = 0; k < N_PORTS; k++) begin
			n = n + ref_t'(m[k]);
		end
		return n;
	endfunction

	// ------------------------------------------------------
	// queue status and write side
	// ------------------------------------------------------
	always_comb begin
		for (int p = 0; p < N_PORTS; p++) begin
			// msb set means QDEPTH entries
			q_full[p] = q_cnt[p][QAW];
			o_q_nonempty[p] = (q_cnt[p] != '0);
			o_q_head[p] = q_mem[p][q_rd[p]];
			pop[p] = i_rd_req && (i_rd_port == port_idx_t'(p));
		end
	end

	assign wr_addr = free_mem[free_rd];
	assign o_par_ready = (free_cnt != '0) && ((i_par_cell.mask & q_full) == '0);
	// zero mask cells are taken and dropped
	assign store = i_par_valid && o_par_ready && (i_par_cell.mask != '0);
	assign push = store ? i_par_cell.mask : '0;
	assign free_push = i_rd_req && (ref_cnt[i_rd_addr] == ref_t'(1));

	always_ff @(posedge clk_80M) begin
		if (store) begin
			mem[wr_addr] <= '{data: i_par_cell.data, first: i_par_cell.first,
				last: i_par_cell.last};
			ref_cnt[wr_addr] <= mask_refs(i_par_cell.mask);
		end
		if (i_rd_req) begin
			ref_cnt[i_rd_addr] <= ref_cnt[i_rd_addr] - 1'b1;
		end
		o_rd_data <= mem[i_rd_addr];
		for (int p = 0; p < N_PORTS; p++) begin
			if (push[p]) begin
				q_mem[p][q_wr[p]] <= wr_addr;
			end
		end
	end

	// ------------------------------------------------------
	// free list and queue pointers
	// ------------------------------------------------------
	always_ff @(posedge clk_80M) begin
		if (i_rst) begin
			free_rd <= '0;
			free_wr <= '0;
			free_cnt <= (BUF_AW + 1)'(DEPTH);
			for (int a = 0; a < DEPTH; a++) begin
				free_mem[a] <= addr_t'(a);
			end
			for (int p = 0; p < N_PORTS; p++) begin
				q_rd[p] <= '0;
				q_wr[p] <= '0;
				q_cnt[p] <= '0;
			end
		end else begin
			if (store) begin
				free_rd <= free_rd + 1'b1;
			end
			if (free_push) begin
				free_mem[free_wr] <= i_rd_addr;
				free_wr <= free_wr + 1'b1;
			end
			if (free_push && !store) begin
				free_cnt <= free_cnt + 1'b1;
			end else if (store && !free_push) begin
				free_cnt <= free_cnt - 1'b1;
			end
			for (int p = 0; p < N_PORTS; p++) begin
				if (push[p]) begin
					q_wr[p] <= q_wr[p] + 1'b1;
				end
				if (pop[p]) begin
					q_rd[p] <= q_rd[p] + 1'b1;
				end
				if (push[p] && !pop[p]) begin
					q_cnt[p] <= q_cnt[p] + 1'b1;
				end else if (pop[p] && !push[p]) begin
					q_cnt[p] <= q_cnt[p] - 1'b1;
				end
			end
		end
	end

	a_free_ovf: assert property (@(posedge clk_80M) disable iff (i_rst)
		(free_push && !store) |-> (free_cnt != (BUF_AW + 1)'(DEPTH)));

	// reader must take the head of a non-empty queue
	a_rd_empty: assert property (@(posedge clk_80M) disable iff (i_rst)
		i_rd_req |-> o_q_nonempty[i_rd_port] && (i_rd_addr == o_q_head[i_rd_port]));

endmodule

//--- source/gsm_hdr_parse.sv
// ----------------------------------------------------------
// header decode stage, one cell register
// tags every cell with the packet mask and first/last flags
// a zero count header is both first and last
// ----------------------------------------------------------
module gsm_hdr_parse (
	input  logic clk_80M,
	input  logic i_rst,
	input  logic i_arb_valid,
	input  gsm_pkg::in_cell_t i_arb_cell,
	input  gsm_pkg::port_idx_t i_arb_src,
	output logic o_arb_ready,
	output logic o_par_valid,
	output gsm_pkg::tag_cell_t o_par_cell,
	input  logic i_par_ready
);
	import gsm_pkg::*;

	port_mask_t mask_q;
	port_mask_t hdr_mask;
	cell_cnt_t left;
	cell_cnt_t hdr_cnt;
	port_idx_t src_q;
	logic accept;

	assign o_arb_ready = !o_par_valid || i_par_ready;
	assign accept = i_arb_valid && o_arb_ready;
	assign hdr_cnt = i_arb_cell.data[HDR_CNT_LSB +: $bits(cell_cnt_t)];
	assign hdr_mask = i_arb_cell.data[HDR_MASK_LSB +: N_PORTS];

	always_ff @(posedge clk_80M) begin
		if (i_rst) begin
			o_par_valid <= 1'b0;
			left <= '0;
		end else begin
			if (accept) begin
				o_par_valid <= 1'b1;
			end else if (i_par_ready) begin
				o_par_valid <= 1'b0;
			end
			if (accept) begin
				left <= i_arb_cell.hdr ? hdr_cnt : left - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_80M) begin
		if (accept && i_arb_cell.hdr) begin
			mask_q <= hdr_mask;
			src_q <= i_arb_src;
			o_par_cell <= '{data: i_arb_cell.data, mask: hdr_mask, first: 1'b1,
				last: (hdr_cnt == '0)};
		end else if (accept) begin
			o_par_cell <= '{data: i_arb_cell.data, mask: mask_q, first: 1'b0,
				last: (left == cell_cnt_t'(1))};
		end
	end

	// data cells belong to an open packet from the same ingress port
	a_same_src: assert property (@(posedge clk_80M) disable iff (i_rst)
		(accept && !i_arb_cell.hdr) |-> (left != '0) && (i_arb_src == src_q));

endmodule

//--- source/gsm_ingress_arb.sv
// ----------------------------------------------------------
// round-robin arbiter over the ingress ports
// grant is held until the last cell of a packet transfers
// every port must start with a header cell
// ----------------------------------------------------------
module gsm_ingress_arb (
	input  logic clk_80M,
	input  logic i_rst,
	input  logic [gsm_pkg::N_PORTS-1:0] i_in_valid,
	input  gsm_pkg::in_cell_t i_in_cell [gsm_pkg::N_PORTS],
	output logic [gsm_pkg::N_PORTS-1:0] o_in_ready,
	output logic o_arb_valid,
	output gsm_pkg::in_cell_t o_arb_cell,
	output gsm_pkg::port_idx_t o_arb_src,
	input  logic i_arb_ready
);
	import gsm_pkg::*;

	typedef enum logic {IDLE, PKT} lock_t;

	lock_t state;
	port_idx_t rr_ptr;
	port_idx_t gnt;
	port_idx_t sel;
	port_idx_t cur;
	cell_cnt_t rem;
	cell_cnt_t hdr_cnt;
	logic run;
	logic xfer;

	// rotating priority search from rr_ptr
	always_comb begin
		port_idx_t idx;
		logic found;
		sel = rr_ptr;
		found = 1'b0;
		for (int k = 0; k < N_PORTS; k++) begin
			idx = rr_ptr + port_idx_t'(k);
			if (!found && i_in_valid[idx]) begin
				sel = idx;
				found = 1'b1;
			end
		end
	end

	assign cur = (state == PKT) ? gnt : sel;
	assign o_arb_valid = run && i_in_valid[cur];
	assign o_arb_cell = i_in_cell[cur];
	assign o_arb_src = cur;
	assign xfer = o_arb_valid && i_arb_ready;
	assign hdr_cnt = o_arb_cell.data[HDR_CNT_LSB +: $bits(cell_cnt_t)];

	always_comb begin
		for (int p = 0; p < N_PORTS; p++) begin
			o_in_ready[p] = run && i_arb_ready && (cur == port_idx_t'(p));
		end
	end

	always_ff @(posedge clk_80M) begin
		if (i_rst) begin
			state <= IDLE;
			rr_ptr <= '0;
			gnt <= '0;
			rem <= '0;
			run <= 1'b0;
		end else begin
			run <= 1'b1;
			if (xfer && state == IDLE) begin
				if (hdr_cnt == '0) begin
					// header-only packet, done at once
					rr_ptr <= sel + 1'b1;
				end else begin
					state <= PKT;
					gnt <= sel;
					rem <= hdr_cnt;
				end
			end else if (xfer) begin
				rem <= rem - 1'b1;
				if (rem == cell_cnt_t'(1)) begin
					state <= IDLE;
					rr_ptr <= gnt + 1'b1;
				end
			end
		end
	end

	a_no_hdr_mid_pkt: assert property (@(posedge clk_80M) disable iff (i_rst)
		(state == PKT && o_arb_valid) |-> !o_arb_cell.hdr);

endmodule

//--- source/gsm_pkg.sv
// ----------------------------------------------------------
// shared types for the 4x4 shared-memory packet switch
// header layout: seq 7..0, src 15..8, count 19..16,
// mask 27..24, upper bits are free payload
// a packet is one header cell and 0 to 15 data cells
// ----------------------------------------------------------
package gsm_pkg;

	localparam int N_PORTS = 4;
	localparam int CELL_W = 64;

	typedef logic [CELL_W-1:0] cell_data_t;
	typedef logic [N_PORTS-1:0] port_mask_t;
	typedef logic [1:0] port_idx_t;
	typedef logic [3:0] cell_cnt_t;

	// header field positions
	localparam int HDR_SEQ_LSB = 0;
	localparam int HDR_SRC_LSB = 8;
	localparam int HDR_CNT_LSB = 16;
	localparam int HDR_MASK_LSB = 24;

	typedef struct packed {
		cell_data_t data;
		logic hdr;
	} in_cell_t;

	typedef struct packed {
		cell_data_t data;
		port_mask_t mask;
		logic first;
		logic last;
	} tag_cell_t;

	typedef struct packed {
		cell_data_t data;
		logic first;
		logic last;
	} out_cell_t;

endpackage
